// ==== list.f ====
lc3b_isa_pkg.sv
ooo_core_pkg.sv
fetch_unit.sv
issue_control.sv
regfile.sv
alu_rs_unit.sv
reorder_buffer.sv
ooo_core_top.sv
tb_ooo_core.sv

// ==== tb_ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;
	import lc3b_isa_pkg::*;

	localparam int prog_len = 200;
	localparam int timeout_cycles = prog_len * 4 * 4 + 500;
	localparam logic [31:0] lfsr_seed = 32'h9d08_1b03;

	// Kind 0 is register mode, 1 is imm5, 2 is NOT
	typedef struct packed
	{
		logic [1:0] kind;
		lc3b_reg dest;
		lc3b_word value;
	} expect_t;

	logic clk = 1'b0;
	logic rst_n;
	lc3b_word imem_rdata;
	logic imem_resp;
	logic imem_read;
	lc3b_word imem_address;
	logic commit_valid;
	lc3b_reg commit_dest;
	lc3b_word commit_value;

	logic [31:0] lfsr_state;
	lc3b_word program_mem [prog_len];
	expect_t expected [$];
	int n_alu = 0;
	int commit_count = 0;
	int cycles = 0;
	int checks [1:5] = '{default: 0};
	int errors [1:5] = '{default: 0};

	// Instruction port monitor state
	logic req_open = 1'b0;
	logic first_seen = 1'b0;
	lc3b_word open_addr;
	lc3b_word last_addr;

	// Responder state
	logic waiting = 1'b0;
	logic [1:0] wait_left;

	ooo_core_top dut0
	(
		.clk, .rst_n,
		.imem_rdata, .imem_resp, .imem_read, .imem_address,
		.commit_valid, .commit_dest, .commit_value
	);

	always #20 clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic lc3b_word word_at(input lc3b_word addr);
		if (int'(addr[15:1]) < prog_len)
			return program_mem[addr[15:1]];
		return 16'h0000;
	endfunction

	function automatic string test_name(input int t);
		case (t)
			1: return "reset state and first fetch";
			2: return "commit order and values";
			3: return "imm5 and NOT results";
			4: return "non-ALU words and commit count";
			default: return "fetch address sequence";
		endcase
	endfunction

	task automatic compare(input int test_id, input string what, input lc3b_word got,
		input lc3b_word exp);
		checks[test_id]++;
		if (got !== exp)
		begin
			errors[test_id]++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Program generation and the in-order reference model
	task automatic build_program();
		lc3b_word regs [num_regs];
		logic [2:0] sel;
		lc3b_opcode opc;
		lc3b_reg dr;
		lc3b_reg sr1;
		lc3b_reg sr2;
		logic imm_mode;
		lc3b_imm5 imm;
		lc3b_word operand;
		expect_t e;
		for (int r = 0; r < num_regs; r++)
			regs[r] = '0;
		for (int i = 0; i < prog_len; i++)
		begin
			sel = 3'(rand_bits(3));
			dr = 3'(rand_bits(3));
			sr1 = 3'(rand_bits(3));
			sr2 = 3'(rand_bits(3));
			imm_mode = 1'(rand_bits(1));
			imm = 5'(rand_bits(5));
			if (sel == 3'd0)
			begin
				opc = 4'(rand_bits(4));
				if (opc == op_add || opc == op_and || opc == op_not)
					opc = opc ^ 4'h2;
				program_mem[i] = {opc, 12'(rand_bits(12))};
				continue;
			end
			operand = imm_mode ? 16'($signed(imm)) : regs[sr2];
			e.kind = imm_mode ? 2'd1 : 2'd0;
			e.dest = dr;
			if (sel <= 3'd3)
				e.value = regs[sr1] + operand;
			else if (sel <= 3'd5)
				e.value = regs[sr1] & operand;
			if (sel <= 3'd5)
			begin
				opc = (sel <= 3'd3) ? op_add : op_and;
				program_mem[i] = imm_mode ? {opc, dr, sr1, 1'b1, imm}
					: {opc, dr, sr1, 3'b000, sr2};
			end
			else
			begin
				e.kind = 2'd2;
				e.value = ~regs[sr1];
				program_mem[i] = {op_not, dr, sr1, 6'b111111};
			end
			regs[dr] = e.value;
			expected.push_back(e);
			n_alu++;
		end
	endtask

	// Memory answers after 0 to 3 wait cycles
	always @(posedge clk)
	begin
		if (rst_n && imem_read && !imem_resp)
		begin
			if (!waiting)
			begin
				waiting = 1'b1;
				wait_left = 2'(rand_bits(2));
			end
			if (wait_left == 2'd0)
			begin
				imem_resp <= 1'b1;
				imem_rdata <= word_at(imem_address);
				waiting = 1'b0;
			end
			else
				wait_left = wait_left - 2'd1;
		end
		else
			imem_resp <= 1'b0;
	end

	// Outputs sampled on the falling edge
	always @(negedge clk)
	begin
		expect_t e;
		if (!rst_n)
		begin
			compare(1, "commit_valid in reset", 16'(commit_valid), 16'h0);
			compare(1, "imem_read in reset", 16'(imem_read), 16'h0);
		end
		else
		begin
			if (imem_read)
			begin
				if (!req_open && !first_seen)
				begin
					compare(1, "first fetch address", imem_address, 16'h0000);
					first_seen = 1'b1;
				end
				else if (!req_open)
					compare(5, "next fetch address", imem_address, last_addr + 16'd2);
				else
					compare(5, "held fetch address", imem_address, open_addr);
				req_open = 1'b1;
				open_addr = imem_address;
				if (imem_resp)
				begin
					req_open = 1'b0;
					last_addr = imem_address;
				end
			end
			if (commit_valid)
			begin
				commit_count++;
				if (expected.size() == 0)
				begin
					errors[4]++;
					$display("Commit to R%0d at %0t came with no ALU instruction left",
						commit_dest, $time);
				end
				else
				begin
					e = expected.pop_front();
					compare(2, "commit_dest", 16'(commit_dest), 16'(e.dest));
					compare(2, "commit_value", commit_value, e.value);
					if (e.kind != 2'd0)
						compare(3, "imm5 or NOT result", commit_value, e.value);
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles == timeout_cycles)
		begin
			$display("Timeout: the program did not finish within %0d cycles", timeout_cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		int total_checks;
		int total_errors;
		rst_n = 1'b0;
		imem_resp = 1'b0;
		imem_rdata = '0;
		lfsr_state = lfsr_seed;
		build_program();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// Done once every ALU instruction retired and fetch ran past the program
		while (!(commit_count >= n_alu && imem_address >= 16'(2 * prog_len)))
			@(posedge clk);
		repeat (16) @(posedge clk);
		compare(4, "total commit count", 16'(commit_count), 16'(n_alu));

		total_checks = 0;
		total_errors = 0;
		for (int t = 1; t <= 5; t++)
		begin
			$display("test %0d (%s): %0d checks, %0d errors", t, test_name(t),
				checks[t], errors[t]);
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("checks passed %0d, failed %0d", total_checks - total_errors, total_errors);
		if (total_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ooo_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top
(
	input  logic clk,
	input  logic rst_n,
	input  lc3b_isa_pkg::lc3b_word imem_rdata,
	input  logic imem_resp,
	output logic imem_read,
	output lc3b_isa_pkg::lc3b_word imem_address,
	output logic commit_valid,
	output lc3b_isa_pkg::lc3b_reg commit_dest,
	output lc3b_isa_pkg::lc3b_word commit_value
);
	import lc3b_isa_pkg::*;
	import ooo_core_pkg::*;

	// Fetch and issue
	lc3b_word ir;
	logic ir_valid;
	logic take;

	// Operand lookup
	lc3b_reg src_a;
	lc3b_reg src_b;
	operand_t rf_a;
	operand_t rf_b;
	operand_t rob_a;
	operand_t rob_b;

	// Allocation and rename
	logic rob_full;
	logic rs_free;
	rob_tag tail_tag;
	rs_issue_t rs_issue;
	rob_alloc_t rob_alloc;
	logic rename_valid;
	lc3b_reg rename_reg;
	rob_tag rename_tag;

	// Results
	cdb_t cdb;
	commit_t commit;

	fetch_unit fetch0
	(
		.clk, .rst_n,
		.imem_rdata, .imem_resp, .imem_read, .imem_address,
		.ir, .ir_valid, .take
	);

	issue_control issue0
	(
		.ir, .ir_valid, .take,
		.src_a, .src_b, .rf_a, .rf_b, .rob_a, .rob_b,
		.rob_full, .tail_tag, .rs_free, .cdb,
		.rs_issue, .rob_alloc,
		.rename_valid, .rename_reg, .rename_tag
	);

	regfile regfile0
	(
		.clk, .rst_n,
		.src_a, .src_b, .rf_a, .rf_b,
		.rename_valid, .rename_reg, .rename_tag,
		.commit
	);

	alu_rs_unit alu_rs0
	(
		.clk, .rst_n,
		.rs_issue, .rs_free, .cdb
	);

	// ROB lookups use the tags the register file holds
	reorder_buffer rob0
	(
		.clk, .rst_n,
		.rob_alloc, .tail_tag, .rob_full, .cdb,
		.tag_a(rf_a.tag), .tag_b(rf_b.tag),
		.rob_a, .rob_b, .commit
	);

	assign commit_valid = commit.valid;
	assign commit_dest = commit.dest;
	assign commit_value = commit.value;

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
(
	input  logic clk,
	input  logic rst_n,
	input  ooo_core_pkg::rob_alloc_t rob_alloc,
	output ooo_core_pkg::rob_tag tail_tag,
	output logic rob_full,
	input  ooo_core_pkg::cdb_t cdb,
	input  ooo_core_pkg::rob_tag tag_a,
	input  ooo_core_pkg::rob_tag tag_b,
	output ooo_core_pkg::operand_t rob_a,
	output ooo_core_pkg::operand_t rob_b,
	output ooo_core_pkg::commit_t commit
);
	import lc3b_isa_pkg::*;
	import ooo_core_pkg::*;

	logic [rob_depth-1:0] ent_valid;
	logic [rob_depth-1:0] ent_ready;
	lc3b_reg ent_dest [rob_depth];
	lc3b_word ent_value [rob_depth];

	rob_tag head;
	rob_tag tail;
	logic [$clog2(rob_depth+1)-1:0] count;
	logic retire;

	assign tail_tag = tail;
	assign rob_full = (count == rob_depth);

	// Head leaves in the cycle after it was marked ready
	assign retire = ent_valid[head] && ent_ready[head];
	assign commit = '{valid: retire, dest: ent_dest[head], tag: head, value: ent_value[head]};

	// Forward finished results that have not retired yet
	assign rob_a = '{ready: ent_valid[tag_a] && ent_ready[tag_a], tag: tag_a,
		value: ent_value[tag_a]};
	assign rob_b = '{ready: ent_valid[tag_b] && ent_ready[tag_b], tag: tag_b,
		value: ent_value[tag_b]};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ent_valid <= '0;
			ent_ready <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (cdb.valid)
				ent_ready[cdb.tag] <= 1'b1;
			if (retire)
			begin
				ent_valid[head] <= 1'b0;
				head <= head + 1'b1;
			end
			// Allocation stops when full so tail never meets a retiring head
			if (rob_alloc.valid)
			begin
				ent_valid[tail] <= 1'b1;
				ent_ready[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			count <= count + rob_alloc.valid - retire;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rob_alloc.valid)
			ent_dest[tail] <= rob_alloc.dest;
		if (cdb.valid)
			ent_value[cdb.tag] <= cdb.value;
	end

	a_cdb_tag_pending: assert property (@(posedge clk) disable iff (!rst_n)
		cdb.valid |-> ent_valid[cdb.tag] && !ent_ready[cdb.tag])
		else $error("CDB tag does not name a pending ROB entry");

endmodule

`default_nettype wire

// ==== alu_rs_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_rs_unit
(
	input  logic clk,
	input  logic rst_n,
	input  ooo_core_pkg::rs_issue_t rs_issue,
	output logic rs_free,
	output ooo_core_pkg::cdb_t cdb
);
	import lc3b_isa_pkg::*;
	import ooo_core_pkg::*;

	localparam int idx_w = $clog2(num_alu_rs);

	// Valid bit of a station doubles as its busy bit
	rs_issue_t st [num_alu_rs];

	logic [idx_w-1:0] free_idx;
	logic [idx_w-1:0] sel_idx;
	logic sel_valid;
	logic dest_in_use;
	lc3b_word result;

	// Downward scan so the lowest index wins
	always_comb
	begin
		rs_free = 1'b0;
		free_idx = '0;
		sel_valid = 1'b0;
		sel_idx = '0;
		dest_in_use = 1'b0;
		for (int i = num_alu_rs - 1; i >= 0; i--)
		begin
			if (!st[i].valid)
			begin
				rs_free = 1'b1;
				free_idx = idx_w'(i);
			end
			if (st[i].valid && st[i].j.ready && st[i].k.ready)
			begin
				sel_valid = 1'b1;
				sel_idx = idx_w'(i);
			end
			if (st[i].valid && st[i].dest == rs_issue.dest)
				dest_in_use = 1'b1;
		end
	end

	always_comb
	begin
		case (st[sel_idx].op)
			alu_add: result = st[sel_idx].j.value + st[sel_idx].k.value;
			alu_and: result = st[sel_idx].j.value & st[sel_idx].k.value;
			alu_not: result = ~(st[sel_idx].j.value & st[sel_idx].k.value);
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < num_alu_rs; i++)
				st[i].valid <= 1'b0;
			cdb.valid <= 1'b0;
		end
		else
		begin
			for (int i = 0; i < num_alu_rs; i++)
			begin
				// Snoop the broadcast for pending operands
				if (cdb.valid && !st[i].j.ready && st[i].j.tag == cdb.tag)
				begin
					st[i].j.ready <= 1'b1;
					st[i].j.value <= cdb.value;
				end
				if (cdb.valid && !st[i].k.ready && st[i].k.tag == cdb.tag)
				begin
					st[i].k.ready <= 1'b1;
					st[i].k.value <= cdb.value;
				end
				if (sel_valid && sel_idx == idx_w'(i))
					st[i].valid <= 1'b0;
			end
			if (rs_issue.valid)
				st[free_idx] <= rs_issue;
			cdb.valid <= sel_valid;
			cdb.tag <= st[sel_idx].dest;
			cdb.value <= result;
		end
	end

	a_issue_has_room: assert property (@(posedge clk) disable iff (!rst_n)
		rs_issue.valid |-> rs_free)
		else $error("issue arrived with all stations busy");

	// ROB tags are unique while in flight, so no two stations share one
	a_dest_unique: assert property (@(posedge clk) disable iff (!rst_n)
		rs_issue.valid |-> !dest_in_use)
		else $error("dest tag already held by a station");

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
(
	input  logic clk,
	input  logic rst_n,
	input  lc3b_isa_pkg::lc3b_reg src_a,
	input  lc3b_isa_pkg::lc3b_reg src_b,
	output ooo_core_pkg::operand_t rf_a,
	output ooo_core_pkg::operand_t rf_b,
	input  logic rename_valid,
	input  lc3b_isa_pkg::lc3b_reg rename_reg,
	input  ooo_core_pkg::rob_tag rename_tag,
	input  ooo_core_pkg::commit_t commit
);
	import lc3b_isa_pkg::*;
	import ooo_core_pkg::*;

	lc3b_word value [num_regs];
	logic [num_regs-1:0] busy;
	rob_tag tag [num_regs];

	// A busy register points at the ROB entry that will write it
	assign rf_a = '{ready: !busy[src_a], tag: tag[src_a], value: value[src_a]};
	assign rf_b = '{ready: !busy[src_b], tag: tag[src_b], value: value[src_b]};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < num_regs; i++)
				value[i] <= '0;
			busy <= '0;
		end
		else
		begin
			if (commit.valid)
			begin
				value[commit.dest] <= commit.value;
				// Only the latest producer frees the register
				if (tag[commit.dest] == commit.tag)
					busy[commit.dest] <= 1'b0;
			end
			// Written last so a rename in the same cycle keeps busy set
			if (rename_valid)
				busy[rename_reg] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rename_valid)
			tag[rename_reg] <= rename_tag;
	end

endmodule

`default_nettype wire

// ==== issue_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_control
(
	input  lc3b_isa_pkg::lc3b_word ir,
	input  logic ir_valid,
	output logic take,
	output lc3b_isa_pkg::lc3b_reg src_a,
	output lc3b_isa_pkg::lc3b_reg src_b,
	input  ooo_core_pkg::operand_t rf_a,
	input  ooo_core_pkg::operand_t rf_b,
	input  ooo_core_pkg::operand_t rob_a,
	input  ooo_core_pkg::operand_t rob_b,
	input  logic rob_full,
	input  ooo_core_pkg::rob_tag tail_tag,
	input  logic rs_free,
	input  ooo_core_pkg::cdb_t cdb,
	output ooo_core_pkg::rs_issue_t rs_issue,
	output ooo_core_pkg::rob_alloc_t rob_alloc,
	output logic rename_valid,
	output lc3b_isa_pkg::lc3b_reg rename_reg,
	output ooo_core_pkg::rob_tag rename_tag
);
	import lc3b_isa_pkg::*;
	import ooo_core_pkg::*;

	lc3b_opcode opcode;
	lc3b_reg dr;
	lc3b_imm5 imm5;
	logic imm_mode;
	logic alu_instr;
	logic fire;
	alu_op_t alu_op;
	operand_t op_j;
	operand_t op_k;

	// Register file first, then the ROB entry, then this cycle's broadcast
	function automatic operand_t resolve(operand_t rf_view, operand_t rob_view, cdb_t bus);
		operand_t res;
		res = rf_view;
		if (!rf_view.ready)
		begin
			if (rob_view.ready)
			begin
				res.ready = 1'b1;
				res.value = rob_view.value;
			end
			else if (bus.valid && bus.tag == rf_view.tag)
			begin
				res.ready = 1'b1;
				res.value = bus.value;
			end
		end
		return res;
	endfunction

	assign opcode = ir[15:12];
	assign dr = ir[11:9];
	assign src_a = ir[8:6];
	assign src_b = ir[2:0];
	assign imm_mode = ir[5];
	assign imm5 = ir[4:0];

	always_comb
	begin
		alu_instr = 1'b1;
		alu_op = alu_add;
		case (opcode)
			op_add: alu_op = alu_add;
			op_and: alu_op = alu_and;
			op_not: alu_op = alu_not;
			default: alu_instr = 1'b0;
		endcase

		op_j = resolve(rf_a, rob_a, cdb);

		// NOT runs as the AND form with an all-ones mask
		if (opcode == op_not)
		begin
			op_k.ready = 1'b1;
			op_k.tag = '0;
			op_k.value = 16'hffff;
		end
		else if (imm_mode)
		begin
			op_k.ready = 1'b1;
			op_k.tag = '0;
			op_k.value = {{11{imm5[4]}}, imm5};
		end
		else
			op_k = resolve(rf_b, rob_b, cdb);
	end

	assign fire = ir_valid && alu_instr && !rob_full && rs_free;

	// Other opcodes leave at once and allocate nothing
	assign take = ir_valid && (!alu_instr || (!rob_full && rs_free));

	assign rs_issue = '{valid: fire, op: alu_op, j: op_j, k: op_k, dest: tail_tag};
	assign rob_alloc = '{valid: fire, dest: dr};

	assign rename_valid = fire;
	assign rename_reg = dr;
	assign rename_tag = tail_tag;

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
(
	input  logic clk,
	input  logic rst_n,
	input  lc3b_isa_pkg::lc3b_word imem_rdata,
	input  logic imem_resp,
	output logic imem_read,
	output lc3b_isa_pkg::lc3b_word imem_address,
	output lc3b_isa_pkg::lc3b_word ir,
	output logic ir_valid,
	input  logic take
);
	import lc3b_isa_pkg::*;

	lc3b_word pc;

	assign imem_address = pc;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc <= '0;
			imem_read <= 1'b0;
			ir_valid <= 1'b0;
		end
		else
		begin
			if (imem_read && imem_resp)
			begin
				// Register is empty whenever a request is out
				imem_read <= 1'b0;
				ir_valid <= 1'b1;
				pc <= pc + 16'd2;
			end
			else
			begin
				if (take)
					ir_valid <= 1'b0;
				// Next request once the register is empty or leaving
				if (!imem_read && (!ir_valid || take))
					imem_read <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (imem_read && imem_resp)
			ir <= imem_rdata;
	end

	// A pending request keeps its address until the memory answers
	a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		imem_read && !imem_resp |=> imem_read && $stable(imem_address))
		else $error("imem_address changed while imem_read waited");

endmodule

`default_nettype wire

// ==== ooo_core_pkg.sv ====
`default_nettype none

package ooo_core_pkg;

	// Machine sizes
	localparam int rob_depth = 8;
	localparam int num_alu_rs = 3;

	// Index of a ROB entry, also the rename tag
	typedef logic [$clog2(rob_depth)-1:0] rob_tag;

	typedef enum logic [1:0]
	{
		alu_add,
		alu_and,
		alu_not
	} alu_op_t;

	// One result broadcast per cycle
	typedef struct packed
	{
		logic valid;
		rob_tag tag;
		lc3b_isa_pkg::lc3b_word value;
	} cdb_t;

	// Value when ready, otherwise the tag that will produce it
	typedef struct packed
	{
		logic ready;
		rob_tag tag;
		lc3b_isa_pkg::lc3b_word value;
	} operand_t;

	typedef struct packed
	{
		logic valid;
		alu_op_t op;
		operand_t j;
		operand_t k;
		rob_tag dest;
	} rs_issue_t;

	typedef struct packed
	{
		logic valid;
		lc3b_isa_pkg::lc3b_reg dest;
	} rob_alloc_t;

	typedef struct packed
	{
		logic valid;
		lc3b_isa_pkg::lc3b_reg dest;
		rob_tag tag;
		lc3b_isa_pkg::lc3b_word value;
	} commit_t;

endpackage

`default_nettype wire

// ==== lc3b_isa_pkg.sv ====
`default_nettype none

package lc3b_isa_pkg;

	// Data and address word
	typedef logic [15:0] lc3b_word;

	// Register index
	typedef logic [2:0] lc3b_reg;

	// Opcode field, bits 15:12
	typedef logic [3:0] lc3b_opcode;

	// Signed immediate of the ALU forms
	typedef logic [4:0] lc3b_imm5;

	// Opcodes handled by the ALU stations
	localparam lc3b_opcode op_add = 4'b0001;
	localparam lc3b_opcode op_and = 4'b0101;
	localparam lc3b_opcode op_not = 4'b1001;

	// Architectural register count
	localparam int num_regs = 8;

endpackage

`default_nettype wire
